// ==== all.f ====
reg_proxy_pkg.sv
proxy_win_bus.sv
reg_bus.sv
proxy_window.sv
reg_proxy.sv
reg_target.sv
reg_proxy_top.sv
tb_reg_proxy.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the register proxy testbench with Verilator.
# A failing check ends in $fatal, so the simulator exit status carries the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_reg_proxy \
    -f all.f \
    -o sim_reg_proxy

./obj_dir/sim_reg_proxy

// ==== tb_reg_proxy.sv ====
// ------------------------------
// Drives the proxy through its AXI4-Lite window and checks against a 16-word model
// Stops at the first mismatch or timeout, every handshake loop is bounded
// ------------------------------
`timescale 1ns/1ps

module tb_reg_proxy
    import reg_proxy_pkg::*;
();

    localparam int          HS_LIMIT   = 50;
    localparam int          POLL_LIMIT = 20;
    localparam int          RAND_TXNS  = 24;
    localparam logic [31:0] LFSR_SEED  = 32'hc225_b439;

    logic                  reg_if;
    logic                  rst_n;
    logic                  awvalid;
    logic                  awready;
    logic [CSR_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic                  bvalid;
    logic                  bready;
    logic [1:0]            bresp;
    logic                  arvalid;
    logic                  arready;
    logic [CSR_ADDR_W-1:0] araddr;
    logic                  rvalid;
    logic                  rready;
    logic [DATA_W-1:0]     rdata;
    logic [1:0]            rresp;

    // Random stall on responses, off for the directed part
    logic                  stall_en;
    logic [31:0]           lfsr_state;
    // Expected target contents
    logic [DATA_W-1:0]     model [TARGET_WORDS];

    reg_proxy_top reg_proxy_top_i (.*);

    initial begin
        reg_if = 1'b0;
        forever #2 reg_if = ~reg_if;
    end

    // ------------------------------
    // Random bits and helpers
    // ------------------------------
    // Galois form, one shift per bit
    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'hA300_0000;
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) val = {val[30:0], lfsr_bit()};
        return val;
    endfunction

    // Byte lane mask, all ones where the enable is set
    function automatic logic [DATA_W-1:0] lane_mask(input logic [STRB_W-1:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge reg_if);
        #1;
    endtask

    // ------------------------------
    // AXI4-Lite master
    // ------------------------------
    task automatic axi_write(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int cnt;
        int stall;
        next_cycle();
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        cnt     = 0;
        // Look at ready mid-cycle
        #1;
        while (!(awready && wready)) begin
            cnt++;
            if (cnt > HS_LIMIT) abort_run("Timeout waiting for awready and wready");
            next_cycle();
            #1;
        end
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cnt     = 0;
        while (!bvalid) begin
            cnt++;
            if (cnt > HS_LIMIT) abort_run("Timeout waiting for bvalid");
            next_cycle();
        end
        expect_value("bresp", 32'(bresp), 32'(AXI_RESP_OKAY));
        stall = stall_en ? int'(rand_bits(2)) : 0;
        repeat (stall) next_cycle();
        // Response must survive the stall
        expect_value("bvalid", 32'(bvalid), 32'h1);
        bready = 1'b1;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [CSR_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int cnt;
        int stall;
        next_cycle();
        arvalid = 1'b1;
        araddr  = addr;
        cnt     = 0;
        #1;
        while (!arready) begin
            cnt++;
            if (cnt > HS_LIMIT) abort_run("Timeout waiting for arready");
            next_cycle();
            #1;
        end
        next_cycle();
        arvalid = 1'b0;
        cnt     = 0;
        while (!rvalid) begin
            cnt++;
            if (cnt > HS_LIMIT) abort_run("Timeout waiting for rvalid");
            next_cycle();
        end
        data = rdata;
        expect_value("rresp", 32'(rresp), 32'(AXI_RESP_OKAY));
        stall = stall_en ? int'(rand_bits(2)) : 0;
        repeat (stall) next_cycle();
        expect_value("rvalid", 32'(rvalid), 32'h1);
        expect_value("rdata", rdata, data);
        rready = 1'b1;
        next_cycle();
        rready = 1'b0;
    endtask

    // Reads STATUS until done, the done read also clears it
    task automatic poll_done(output logic [DATA_W-1:0] status);
        int polls;
        polls = 0;
        axi_read(WIN_STATUS, status);
        while (!status[STAT_DONE_BIT]) begin
            polls++;
            if (polls > POLL_LIMIT) abort_run("Timeout polling STATUS for done");
            axi_read(WIN_STATUS, status);
        end
    endtask

    // ------------------------------
    // One proxied access
    // ------------------------------
    task automatic run_access(input logic is_wr, input logic [REG_ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] be,
                              input logic exp_error);
        logic [DATA_W-1:0] status;
        logic [DATA_W-1:0] mask;
        axi_write(WIN_ADDRESS, addr);
        if (is_wr) begin
            axi_write(WIN_WR_DATA, data);
            axi_write(WIN_BYTE_EN, DATA_W'(be));
        end
        axi_write(WIN_COMMAND, DATA_W'(is_wr));
        poll_done(status);
        expect_value("status.ready", 32'(status[STAT_READY_BIT]), 32'h1);
        expect_value("status.error", 32'(status[STAT_ERROR_BIT]), 32'(exp_error));
        // Good writes land in the model
        if (is_wr && !exp_error) begin
            mask = lane_mask(be);
            model[addr[TARGET_IDX_W+1:2]] = (model[addr[TARGET_IDX_W+1:2]] & ~mask) |
                                            (data & mask);
        end
    endtask

    initial begin
        logic [DATA_W-1:0]       rd;
        logic [DATA_W-1:0]       wdat;
        logic [STRB_W-1:0]       be;
        logic [TARGET_IDX_W-1:0] idx;
        logic                    is_wr;
        rst_n      = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        stall_en   = 1'b0;
        lfsr_state = LFSR_SEED;
        for (int i = 0; i < TARGET_WORDS; i++) model[i] = '0;
        repeat (3) @(posedge reg_if);
        #1;
        rst_n = 1'b1;
        repeat (2) next_cycle();

        // Idle status and unmapped offset
        axi_read(WIN_STATUS, rd);
        expect_value("status", rd, 32'h0000_0001);
        axi_read(8'h1C, rd);
        expect_value("rdata", rd, BAD_ACCESS_DATA);

        // Full word write then read back
        wdat = rand_bits(32);
        run_access(1'b1, 32'h08, wdat, 4'hF, 1'b0);
        run_access(1'b0, 32'h08, '0, '0, 1'b0);
        axi_read(WIN_RD_DATA, rd);
        expect_value("rd_data", rd, wdat);

        // Partial byte enables on the same word
        run_access(1'b1, 32'h08, 32'hA5A5_5A5A, 4'b0101, 1'b0);
        run_access(1'b0, 32'h08, '0, '0, 1'b0);
        axi_read(WIN_RD_DATA, rd);
        expect_value("rd_data", rd, model[2]);

        // Out of range write, then misaligned read
        run_access(1'b1, 32'h40, 32'h1234_5678, 4'hF, 1'b1);
        axi_read(WIN_RD_DATA, rd);
        expect_value("rd_data", rd, BAD_ACCESS_DATA);
        axi_read(WIN_STATUS, rd);
        expect_value("status", rd, 32'h0000_0001);
        run_access(1'b0, 32'h06, '0, '0, 1'b1);
        axi_read(WIN_RD_DATA, rd);
        expect_value("rd_data", rd, BAD_ACCESS_DATA);
        axi_read(WIN_STATUS, rd);
        expect_value("status", rd, 32'h0000_0001);

        // ------------------------------
        // Random mix with response stalls
        // ------------------------------
        stall_en = 1'b1;
        for (int n = 0; n < RAND_TXNS; n++) begin
            is_wr = lfsr_bit();
            idx   = TARGET_IDX_W'(rand_bits(TARGET_IDX_W));
            wdat  = rand_bits(32);
            be    = STRB_W'(rand_bits(STRB_W));
            if (is_wr) begin
                run_access(1'b1, REG_ADDR_W'({idx, 2'b00}), wdat, be, 1'b0);
            end else begin
                run_access(1'b0, REG_ADDR_W'({idx, 2'b00}), '0, '0, 1'b0);
                axi_read(WIN_RD_DATA, rd);
                expect_value("rd_data", rd, model[idx]);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_reg_proxy

// ==== reg_proxy_top.sv ====
// ----------------------------
// Register proxy with its stand-in target, plain AXI4-Lite ports
// ----------------------------
`timescale 1ns/1ps

module reg_proxy_top
    import reg_proxy_pkg::*;
(
    input  logic                  reg_if,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [CSR_ADDR_W-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [STRB_W-1:0]     wstrb,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [CSR_ADDR_W-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp
);

    // Window to engine, engine to target
    proxy_win_bus win_bus_i ();
    reg_bus       reg_bus_i ();

    proxy_window proxy_window_i (
        .reg_if  (reg_if),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .win     (win_bus_i.window)
    );

    reg_proxy reg_proxy_i (
        .reg_if (reg_if),
        .rst_n  (rst_n),
        .win    (win_bus_i.engine),
        .bus    (reg_bus_i.controller)
    );

    reg_target reg_target_i (
        .reg_if (reg_if),
        .rst_n  (rst_n),
        .bus    (reg_bus_i.target)
    );

endmodule : reg_proxy_top

// ==== reg_target.sv ====
// ----------------------------
// Stand-in register bank for word-aligned byte addresses below 16 words
// Bad writes are dropped and bad reads return zero with error
// ----------------------------
`timescale 1ns/1ps

module reg_target
    import reg_proxy_pkg::*;
(
    input  logic      reg_if,
    input  logic      rst_n,
    reg_bus.target    bus
);

    logic [DATA_W-1:0]     mem [TARGET_WORDS];
    logic [ACK_CNT_W-1:0]  ack_cnt;
    logic                  pend_wr;
    logic [REG_ADDR_W-1:0] pend_addr;
    logic [DATA_W-1:0]     pend_data;
    logic [STRB_W-1:0]     pend_be;
    logic                  pend_ok;
    logic [TARGET_IDX_W-1:0] pend_idx;
    logic                  complete;

    // Capture the request on its strobe
    always_ff @(posedge reg_if) begin
        if (bus.wr || bus.rd) begin
            pend_wr   <= bus.wr;
            pend_addr <= bus.wr ? bus.wr_addr : bus.rd_addr;
            pend_data <= bus.wr_data;
            pend_be   <= bus.wr_byte_en;
        end
    end

    // Aligned and inside the bank
    assign pend_ok  = (pend_addr[1:0] == 2'b00) &&
                      ((pend_addr >> (TARGET_IDX_W + 2)) == '0);
    assign pend_idx = pend_addr[TARGET_IDX_W+1:2];

    // ----------------------------
    // Ack delay
    // ----------------------------
    // Zero means idle and the ack is registered on the last count
    assign complete = (ack_cnt == ACK_CNT_W'(1));

    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            ack_cnt      <= '0;
            bus.wr_ack   <= 1'b0;
            bus.rd_ack   <= 1'b0;
            bus.wr_error <= 1'b0;
            bus.rd_error <= 1'b0;
        end else begin
            bus.wr_ack <= complete && pend_wr;
            bus.rd_ack <= complete && !pend_wr;
            if (complete) begin
                bus.wr_error <= !pend_ok;
                bus.rd_error <= !pend_ok;
            end
            if (bus.wr || bus.rd) begin
                ack_cnt <= ACK_CNT_W'(TARGET_ACK_DELAY - 1);
            end else if (ack_cnt != '0) begin
                ack_cnt <= ack_cnt - ACK_CNT_W'(1);
            end
        end
    end

    // ----------------------------
    // Storage
    // ----------------------------
    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            for (int i = 0; i < TARGET_WORDS; i++) mem[i] <= '0;
        end else if (complete && pend_wr && pend_ok) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (pend_be[b]) mem[pend_idx][8*b +: 8] <= pend_data[8*b +: 8];
            end
        end
    end

    // Read data lines up with rd_ack
    always_ff @(posedge reg_if) begin
        if (complete && !pend_wr) bus.rd_data <= pend_ok ? mem[pend_idx] : '0;
    end

endmodule : reg_target

// ==== reg_proxy.sv ====
// ----------------------------
// One downstream access per command, commands outside READY are dropped
// Context stays stable on the bus from strobe to ack
// ----------------------------
`timescale 1ns/1ps

module reg_proxy
    import reg_proxy_pkg::*;
(
    input  logic         reg_if,
    input  logic         rst_n,
    proxy_win_bus.engine win,
    reg_bus.controller   bus
);

    proxy_state_t          state;
    proxy_state_t          nxt_state;
    logic [REG_ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0]     wr_data_q;
    logic [STRB_W-1:0]     byte_en_q;
    logic [DATA_W-1:0]     rd_data_q;
    logic                  done_q;
    logic                  error_q;

    // ----------------------------
    // Transaction FSM
    // ----------------------------
    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: begin
                nxt_state = READY;
            end
            READY: begin
                // Direction comes straight off the command write
                if (win.command_wr_evt) begin
                    nxt_state = win.wr_rd_n ? WRITE : READ;
                end
            end
            // Strobe cycles last exactly one clock
            WRITE: begin
                nxt_state = WRITE_ACK;
            end
            READ: begin
                nxt_state = READ_ACK;
            end
            WRITE_ACK: begin
                if (bus.wr_ack) nxt_state = bus.wr_error ? ERROR : DONE;
            end
            READ_ACK: begin
                if (bus.rd_ack) nxt_state = bus.rd_error ? ERROR : DONE;
            end
            DONE: begin
                nxt_state = READY;
            end
            ERROR: begin
                nxt_state = READY;
            end
            default: begin
                nxt_state = RESET;
            end
        endcase
    end

    // ----------------------------
    // Downstream context
    // ----------------------------
    // Tracks the window while idle, frozen once a command is taken
    always_ff @(posedge reg_if) begin
        if (state == READY) begin
            addr_q    <= win.address;
            wr_data_q <= win.wr_data;
            byte_en_q <= win.wr_byte_en;
        end
    end

    assign bus.wr         = (state == WRITE);
    assign bus.rd         = (state == READ);
    assign bus.wr_addr    = addr_q;
    assign bus.wr_data    = wr_data_q;
    assign bus.wr_byte_en = byte_en_q;
    // Same latched address for both directions
    assign bus.rd_addr    = addr_q;

    // Read result from the target
    always_ff @(posedge reg_if) begin
        if (bus.rd_ack) rd_data_q <= bus.rd_data;
    end

    // ----------------------------
    // Status flags
    // ----------------------------
    // A completion in the same cycle as a status read wins
    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            if (win.status_rd_evt) begin
                done_q  <= 1'b0;
                error_q <= 1'b0;
            end
            if (state == DONE) begin
                done_q  <= 1'b1;
                error_q <= 1'b0;
            end else if (state == ERROR) begin
                done_q  <= 1'b1;
                error_q <= 1'b1;
            end
        end
    end

    assign win.ready = (state == READY);
    assign win.done  = done_q;
    assign win.error = error_q;

    // Writes reload the last read value, errors load the bad-access pattern
    assign win.rd_data_load  = (state == DONE) || (state == ERROR);
    assign win.rd_data_value = (state == ERROR) ? BAD_ACCESS_DATA : rd_data_q;

endmodule : reg_proxy

// ==== proxy_window.sv ====
// ----------------------------
// AXI4-Lite slave for the proxy window, responses always OKAY
// AW and W must arrive together, one request of each kind in flight
// ----------------------------
`timescale 1ns/1ps

module proxy_window
    import reg_proxy_pkg::*;
(
    input  logic                  reg_if,
    input  logic                  rst_n,
    // Write address and data
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [CSR_ADDR_W-1:0] awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [STRB_W-1:0]     wstrb,
    // Write response
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    // Read address and data
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [CSR_ADDR_W-1:0] araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_W-1:0]     rdata,
    output logic [1:0]            rresp,
    // Engine side
    proxy_win_bus.window          win
);

    logic                  wr_accept;
    logic                  rd_accept;
    logic [REG_ADDR_W-1:0] address_q;
    logic [DATA_W-1:0]     wr_data_q;
    logic [STRB_W-1:0]     byte_en_q;
    logic [DATA_W-1:0]     rd_data_q;
    logic [DATA_W-1:0]     status_word;
    logic [DATA_W-1:0]     rd_word;

    // Merge a write into a word, one byte lane per strobe bit
    function automatic logic [DATA_W-1:0] apply_strb(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

    // ----------------------------
    // Write channel
    // ----------------------------
    // Take AW and W together, held off while a response waits
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign bresp     = AXI_RESP_OKAY;

    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Window registers, writes to read-only offsets are dropped
    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            address_q <= '0;
            wr_data_q <= '0;
            byte_en_q <= '1;
        end else if (wr_accept) begin
            case (awaddr)
                WIN_ADDRESS: address_q <= apply_strb(address_q, wdata, wstrb);
                WIN_WR_DATA: wr_data_q <= apply_strb(wr_data_q, wdata, wstrb);
                WIN_BYTE_EN: begin
                    if (wstrb[0]) byte_en_q <= wdata[STRB_W-1:0];
                end
                default: ;
            endcase
        end
    end

    // Command kicks off the engine in the accept cycle
    assign win.command_wr_evt = wr_accept && (awaddr == WIN_COMMAND);
    assign win.wr_rd_n        = wdata[CMD_WR_RD_N_BIT];
    assign win.address        = address_q;
    assign win.wr_data        = wr_data_q;
    assign win.wr_byte_en     = byte_en_q;

    // Result word, loaded by the engine at the end of each transaction
    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            rd_data_q <= '0;
        end else if (win.rd_data_load) begin
            rd_data_q <= win.rd_data_value;
        end
    end

    // ----------------------------
    // Read channel
    // ----------------------------
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;
    assign rresp     = AXI_RESP_OKAY;

    // Sampled at read time, so the clear below lands after capture
    always_comb begin
        status_word                 = '0;
        status_word[STAT_READY_BIT] = win.ready;
        status_word[STAT_DONE_BIT]  = win.done;
        status_word[STAT_ERROR_BIT] = win.error;
    end

    assign win.status_rd_evt = rd_accept && (araddr == WIN_STATUS);

    // Offset decode, COMMAND is write only
    always_comb begin
        case (araddr)
            WIN_STATUS:  rd_word = status_word;
            WIN_ADDRESS: rd_word = address_q;
            WIN_WR_DATA: rd_word = wr_data_q;
            WIN_BYTE_EN: rd_word = DATA_W'(byte_en_q);
            WIN_RD_DATA: rd_word = rd_data_q;
            default:     rd_word = BAD_ACCESS_DATA;
        endcase
    end

    always_ff @(posedge reg_if) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Held until rready
    always_ff @(posedge reg_if) begin
        if (rd_accept) rdata <= rd_word;
    end

endmodule : proxy_window

// ==== reg_bus.sv ====
// ----------------------------
// Downstream register bus, one strobe outstanding at a time
// Error flags are valid only with their ack
// ----------------------------
`timescale 1ns/1ps

interface reg_bus
    import reg_proxy_pkg::*;
();

    // Controller side strobes and context
    logic                  wr;
    logic                  rd;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0]     wr_data;
    logic [STRB_W-1:0]     wr_byte_en;
    logic [REG_ADDR_W-1:0] rd_addr;

    // Target side responses
    logic                  wr_ack;
    logic                  wr_error;
    logic                  rd_ack;
    logic [DATA_W-1:0]     rd_data;
    logic                  rd_error;

    modport controller (
        output wr, rd, wr_addr, wr_data, wr_byte_en, rd_addr,
        input  wr_ack, wr_error, rd_ack, rd_data, rd_error
    );

    modport target (
        input  wr, rd, wr_addr, wr_data, wr_byte_en, rd_addr,
        output wr_ack, wr_error, rd_ack, rd_data, rd_error
    );

endinterface : reg_bus

// ==== proxy_win_bus.sv ====
// ----------------------------
// Window registers to transaction FSM
// Events are single-cycle pulses, the rest are levels
// ----------------------------
`timescale 1ns/1ps

interface proxy_win_bus
    import reg_proxy_pkg::*;
();

    // From the window side
    logic                  command_wr_evt;
    // Only meaningful together with command_wr_evt
    logic                  wr_rd_n;
    logic [REG_ADDR_W-1:0] address;
    logic [DATA_W-1:0]     wr_data;
    logic [STRB_W-1:0]     wr_byte_en;
    logic                  status_rd_evt;

    // From the engine side
    logic                  ready;
    logic                  done;
    logic                  error;
    logic                  rd_data_load;
    logic [DATA_W-1:0]     rd_data_value;

    modport window (
        output command_wr_evt, wr_rd_n, address, wr_data, wr_byte_en, status_rd_evt,
        input  ready, done, error, rd_data_load, rd_data_value
    );

    modport engine (
        input  command_wr_evt, wr_rd_n, address, wr_data, wr_byte_en, status_rd_evt,
        output ready, done, error, rd_data_load, rd_data_value
    );

endinterface : proxy_win_bus

// ==== reg_proxy_pkg.sv ====
// ----------------------------
// Shared widths, window map and target constants for the register proxy
// TARGET_ACK_DELAY must be 2 or more
// ----------------------------
package reg_proxy_pkg;

    // ----------------------------
    // Widths
    // ----------------------------
    localparam int DATA_W     = 32;
    localparam int CSR_ADDR_W = 8;
    localparam int REG_ADDR_W = 32;
    localparam int STRB_W     = 4;

    // ----------------------------
    // Window offsets
    // ----------------------------
    localparam logic [CSR_ADDR_W-1:0] WIN_COMMAND = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] WIN_STATUS  = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] WIN_ADDRESS = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] WIN_WR_DATA = 8'h0C;
    localparam logic [CSR_ADDR_W-1:0] WIN_BYTE_EN = 8'h10;
    localparam logic [CSR_ADDR_W-1:0] WIN_RD_DATA = 8'h14;

    // Command and status bit fields
    localparam int CMD_WR_RD_N_BIT = 0;
    localparam int STAT_READY_BIT  = 0;
    localparam int STAT_DONE_BIT   = 1;
    localparam int STAT_ERROR_BIT  = 2;

    // AXI response code, only OKAY is ever returned
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // Returned on errors and unmapped window reads
    localparam logic [DATA_W-1:0] BAD_ACCESS_DATA = 32'hDEAD_BEEF;

    // ----------------------------
    // Target bank
    // ----------------------------
    localparam int TARGET_WORDS     = 16;
    localparam int TARGET_IDX_W     = $clog2(TARGET_WORDS);
    localparam int TARGET_ACK_DELAY = 3;
    localparam int ACK_CNT_W        = $clog2(TARGET_ACK_DELAY + 1);

    // Transaction FSM states
    typedef enum logic [2:0] {
        RESET,
        READY,
        WRITE,
        READ,
        WRITE_ACK,
        READ_ACK,
        DONE,
        ERROR
    } proxy_state_t;

endpackage : reg_proxy_pkg
